//--- all.f
pkg_tpu.sv
pkg_isa.sv
issue_decode.sv
reg_file.sv
bypass_buff.sv
network_s.sv
exec_unit.sv
lane_top.sv
tb_lane.sv

//--- bypass_buff.sv
// Bypass window of recent writebacks forwarding the newest match per source index
`timescale 1ns/1ps
`default_nettype none

module bypass_buff
	import pkg_tpu::*;
#(
	parameter int BUFF_SIZE	= 4
)(
	input	logic		clock,
	input	logic		reset,
	input	wb_t		wb,							// Live writeback
	input	index_t		idx1,
	input	index_t		idx2,
	input	index_t		idx3,
	input	data_t		src1,						// Register file values
	input	data_t		src2,
	input	data_t		src3,
	output	data_t		out1,						// Corrected operands
	output	data_t		out2,
	output	data_t		out3
);

	wb_t				win [BUFF_SIZE];			// Entry 0 is the newest

	////////////////////
	// Window shift
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < BUFF_SIZE; i++)
				win[i].valid <= 1'b0;
		end
		else if (wb.valid) begin
			win[0] <= wb;							// Only real writes enter
			for (int i = 1; i < BUFF_SIZE; i++)
				win[i] <= win[i-1];
		end
	end

	// Newest match wins. Walk oldest to newest, then the live writeback
	function automatic data_t lookup(input index_t idx, input data_t reg_val);
		data_t	val;
		val = reg_val;								// No match, keep register value
		for (int i = BUFF_SIZE-1; i >= 0; i--) begin
			if (win[i].valid && (win[i].dst == idx))
				val = win[i].data;
		end
		if (wb.valid && (wb.dst == idx))
			val = wb.data;							// Live result beats window
		return val;
	endfunction

	////////////////////
	// Source correction
	always_comb begin
		out1 = lookup(idx1, src1);
		out2 = lookup(idx2, src2);
		out3 = lookup(idx3, src3);
	end

endmodule

`default_nettype wire

//--- exec_unit.sv
// ALU stage producing the registered writeback and PAC results of the lane
`timescale 1ns/1ps
`default_nettype none

module exec_unit
	import pkg_tpu::*;
(
	input	logic		clock,
	input	logic		reset,
	input	opnd_t		opnd,						// From operand network
	output	wb_t		wb,							// To regfile, network and top
	output	logic		pac_valid,
	output	data_t		pac_data
);

	data_t				a;							// Operands after last-result forward
	data_t				b;
	data_t				c;
	data_t				alu_res;
	data_t				wb_val;
	data_t				pac_val;

	// Previous instruction was still here when the network sampled its sources
	always_comb begin
		a = (wb.valid && (wb.dst == opnd.dec.src1_idx)) ? wb.data : opnd.data1;
		b = (wb.valid && (wb.dst == opnd.dec.src2_idx) && !opnd.dec.imm_en) ?
			wb.data : opnd.data2;					// Immediate never forwarded over
		c = (wb.valid && (wb.dst == opnd.dec.src3_idx)) ? wb.data : opnd.data3;
	end

	////////////////////
	// ALU and path select
	always_comb begin
		case (opnd.dec.op)
			ALU_ADD:	alu_res = a + b;			// Also ADDI
			ALU_SUB:	alu_res = a - b;
			ALU_AND:	alu_res = a & b;
			ALU_OR:		alu_res = a | b;
			ALU_XOR:	alu_res = a ^ b;
			ALU_MAD:	alu_res = a * b + c;		// Truncated to 32 bits
			default:	alu_res = a + b;
		endcase

		case (opnd.dec.sel_path_wb)
			PATH_SRC1:	wb_val = a;					// MOV
			PATH_SRC2:	wb_val = b;
			PATH_SRC3:	wb_val = c;
			default:	wb_val = alu_res;
		endcase

		case (opnd.dec.sel_path)
			PATH_SRC1:	pac_val = a;
			PATH_SRC2:	pac_val = b;
			PATH_SRC3:	pac_val = c;
			default:	pac_val = '0;				// PATH_NONE
		endcase
	end

	////////////////////
	// Output registers
	always_ff @(posedge clock) begin
		if (reset) begin
			wb			<= '0;
			pac_valid	<= 1'b0;
			pac_data	<= '0;
		end
		else begin
			wb.valid	<= opnd.dec.valid && opnd.dec.we;
			pac_valid	<= opnd.dec.valid && (opnd.dec.sel_path != PATH_NONE);
			if (opnd.dec.valid && opnd.dec.we) begin
				wb.dst	<= opnd.dec.dst;			// Hold last result otherwise
				wb.data	<= wb_val;
			end
			if (opnd.dec.valid && (opnd.dec.sel_path != PATH_NONE))
				pac_data <= pac_val;
		end
	end

endmodule

`default_nettype wire

//--- issue_decode.sv
// Decode stage turning a strobed instruction word into the decoded control struct
`timescale 1ns/1ps
`default_nettype none

module issue_decode
	import pkg_tpu::*;
	import pkg_isa::*;
(
	input	logic		clock,
	input	logic		reset,
	input	logic		instr_valid,				// One-cycle strobe
	input	instr_t		instr,
	output	dec_t		dec							// To register read
);

	dec_t				dec_next;

	always_comb begin
		dec_next				= '0;
		dec_next.dst			= instr.r.dst;		// Register form by default
		dec_next.src1_idx		= instr.r.src1;
		dec_next.src2_idx		= instr.r.src2;
		dec_next.src3_idx		= instr.r.src3;
		dec_next.sel_path		= PATH_NONE;
		dec_next.sel_path_wb	= PATH_NONE;		// ALU result
		dec_next.op				= ALU_ADD;

		case (instr.r.opcode)
			OP_ADD:		dec_next.op = ALU_ADD;
			OP_SUB:		dec_next.op = ALU_SUB;
			OP_AND:		dec_next.op = ALU_AND;
			OP_OR:		dec_next.op = ALU_OR;
			OP_XOR:		dec_next.op = ALU_XOR;
			OP_MAD:		dec_next.op = ALU_MAD;
			default:	dec_next.op = ALU_ADD;		// ADDI and non-ALU ops
		endcase

		case (instr.r.opcode)
			OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_MAD: begin
				dec_next.valid		= instr_valid;
				dec_next.we			= 1'b1;
			end
			OP_ADDI: begin							// Word read as immediate form
				dec_next.valid		= instr_valid;
				dec_next.we			= 1'b1;
				dec_next.dst		= instr.i.dst;
				dec_next.src1_idx	= instr.i.src1;
				dec_next.src2_idx	= '0;			// Port unused, imm takes over
				dec_next.src3_idx	= '0;
				dec_next.imm_en		= 1'b1;
				dec_next.imm		= data_t'($signed(instr.i.imm));
			end
			OP_MOV: begin
				dec_next.valid		= instr_valid;
				dec_next.we			= 1'b1;
				dec_next.sel_path_wb	= PATH_SRC1;	// Copy source 1
			end
			OP_PAC: begin
				// pac_sel of 0 names no source, dropped
				dec_next.valid		= instr_valid && (instr.r.pac_sel != 2'd0);
				dec_next.sel_path	= path_t'(instr.r.pac_sel);
			end
			default: ;								// NOP and unknown stay invalid
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset)
			dec <= '0;
		else
			dec <= dec_next;
	end

endmodule

`default_nettype wire

//--- lane_top.sv
// Lane top chaining decode, register read, operand network and ALU stages
`timescale 1ns/1ps
`default_nettype none

module lane_top
	import pkg_tpu::*;
	import pkg_isa::*;
#(
	parameter int NUM_REGS			= pkg_tpu::NUM_REGS,
	parameter int BYPASS_BUFF_SIZE	= pkg_tpu::BYPASS_BUFF_SIZE
)(
	input	logic		clock,
	input	logic		reset,
	input	logic		instr_valid,				// Strobe, no back-pressure
	input	instr_t		instr,
	output	logic		result_valid,				// 4 cycles after strobe
	output	index_t		result_dst,
	output	data_t		result_data,
	output	logic		pac_valid,
	output	data_t		pac_data
);

	dec_t				dec;						// Decode to regfile
	opnd_t				opnd_rf;					// Regfile to network
	opnd_t				opnd_net;					// Network to exec
	wb_t				wb;							// Writeback loop

	issue_decode decode0 (
		.clock			(clock),
		.reset			(reset),
		.instr_valid	(instr_valid),
		.instr			(instr),
		.dec			(dec)
	);

	reg_file #(
		.NUM_REGS		(NUM_REGS)
	) regs0 (
		.clock			(clock),
		.reset			(reset),
		.dec			(dec),
		.wb				(wb),
		.opnd			(opnd_rf)
	);

	network_s #(
		.BYPASS_BUFF_SIZE	(BYPASS_BUFF_SIZE)
	) network0 (
		.clock			(clock),
		.reset			(reset),
		.opnd_in		(opnd_rf),
		.wb				(wb),
		.opnd_out		(opnd_net)
	);

	exec_unit exec0 (
		.clock			(clock),
		.reset			(reset),
		.opnd			(opnd_net),
		.wb				(wb),
		.pac_valid		(pac_valid),
		.pac_data		(pac_data)
	);

	assign result_valid	= wb.valid;
	assign result_dst	= wb.dst;
	assign result_data	= wb.data;

endmodule

`default_nettype wire

//--- network_s.sv
// Operand network correcting sources through the bypass window ahead of the ALU
`timescale 1ns/1ps
`default_nettype none

module network_s
	import pkg_tpu::*;
#(
	parameter int BYPASS_BUFF_SIZE	= pkg_tpu::BYPASS_BUFF_SIZE
)(
	input	logic		clock,
	input	logic		reset,
	input	opnd_t		opnd_in,					// From register file
	input	wb_t		wb,							// From exec unit
	output	opnd_t		opnd_out					// To exec unit
);

	data_t				fwd1;						// Bypass-corrected sources
	data_t				fwd2;
	data_t				fwd3;
	opnd_t				opnd_next;

	bypass_buff #(
		.BUFF_SIZE	(BYPASS_BUFF_SIZE)
	) bypass0 (
		.clock		(clock),
		.reset		(reset),
		.wb			(wb),
		.idx1		(opnd_in.dec.src1_idx),
		.idx2		(opnd_in.dec.src2_idx),
		.idx3		(opnd_in.dec.src3_idx),
		.src1		(opnd_in.data1),
		.src2		(opnd_in.data2),
		.src3		(opnd_in.data3),
		.out1		(fwd1),
		.out2		(fwd2),
		.out3		(fwd3)
	);

	////////////////////
	// Operand select
	always_comb begin
		opnd_next		= opnd_in;					// Control and path selects pass on
		opnd_next.data1	= fwd1;
		opnd_next.data2	= opnd_in.dec.imm_en ? opnd_in.dec.imm : fwd2;	// ADDI imm
		opnd_next.data3	= fwd3;
	end

	always_ff @(posedge clock) begin
		if (reset)
			opnd_out <= '0;
		else
			opnd_out <= opnd_next;
	end

endmodule

`default_nettype wire

//--- pkg_isa.sv
// Lane instruction set package with opcodes and the two instruction word forms
`default_nettype none

package pkg_isa;

	localparam int WIDTH_OPCODE		= 6;
	localparam int WIDTH_REG_IDX	= 5;
	localparam int WIDTH_IMM		= 16;

	typedef logic [WIDTH_REG_IDX-1:0]	reg_idx_t;

	typedef enum logic [WIDTH_OPCODE-1:0] {
		OP_NOP	= 6'h00,
		OP_ADD	= 6'h01,
		OP_SUB	= 6'h02,
		OP_AND	= 6'h03,
		OP_OR	= 6'h04,
		OP_XOR	= 6'h05,
		OP_MAD	= 6'h06,							// Multiply-add
		OP_ADDI	= 6'h07,							// Immediate form
		OP_MOV	= 6'h08,							// dst = src1
		OP_PAC	= 6'h09								// Emit one source on PAC port
	} opcode_t;

	////////////////////
	// Register form
	typedef struct packed {
		opcode_t		opcode;						// [31:26]
		reg_idx_t		dst;						// [25:21]
		reg_idx_t		src1;						// [20:16]
		reg_idx_t		src2;						// [15:11]
		reg_idx_t		src3;						// [10:6]
		logic [1:0]		pac_sel;					// [5:4] PAC source 1 to 3
		logic [3:0]		rsvd;						// [3:0]
	} r_form_t;

	// Immediate form, shares opcode/dst/src1 positions
	typedef struct packed {
		opcode_t				opcode;
		reg_idx_t				dst;
		reg_idx_t				src1;
		logic [WIDTH_IMM-1:0]	imm;				// Signed
	} i_form_t;

	typedef union packed {
		r_form_t	r;
		i_form_t	i;
	} instr_t;

endpackage

`default_nettype wire

//--- pkg_tpu.sv
// Lane datapath package with data words, stage structs and lane sizing constants
`default_nettype none

package pkg_tpu;

	////////////////////
	// Lane sizing
	localparam int WIDTH_DATA		= 32;			// Lane word
	localparam int WIDTH_INDEX		= 5;			// Register index
	localparam int NUM_REGS			= 32;			// Register count
	localparam int BYPASS_BUFF_SIZE	= 4;			// Default bypass window depth

	typedef logic [WIDTH_DATA-1:0]	data_t;
	typedef logic [WIDTH_INDEX-1:0]	index_t;

	// Path select, 0 is none or ALU
	typedef logic [1:0]				path_t;
	localparam path_t PATH_NONE		= 2'd0;
	localparam path_t PATH_SRC1		= 2'd1;
	localparam path_t PATH_SRC2		= 2'd2;
	localparam path_t PATH_SRC3		= 2'd3;

	typedef enum logic [2:0] {
		ALU_ADD,									// src1 + src2
		ALU_SUB,									// src1 - src2
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_MAD										// src1 * src2 + src3
	} alu_op_t;

	////////////////////
	// Stage structs
	typedef struct packed {
		logic		valid;
		alu_op_t	op;
		index_t		dst;
		index_t		src1_idx;
		index_t		src2_idx;
		index_t		src3_idx;
		logic		imm_en;							// Source 2 is the immediate
		data_t		imm;							// Already sign-extended
		path_t		sel_path;						// PAC source
		path_t		sel_path_wb;					// Writeback source
		logic		we;								// Writes dst
	} dec_t;

	typedef struct packed {
		dec_t		dec;
		data_t		data1;
		data_t		data2;
		data_t		data3;
	} opnd_t;

	typedef struct packed {
		logic		valid;
		index_t		dst;
		data_t		data;
	} wb_t;

endpackage

`default_nettype wire

//--- reg_file.sv
// Lane register file with three registered read ports and one write port
`timescale 1ns/1ps
`default_nettype none

module reg_file
	import pkg_tpu::*;
#(
	parameter int NUM_REGS	= pkg_tpu::NUM_REGS
)(
	input	logic		clock,
	input	logic		reset,
	input	dec_t		dec,						// From decode
	input	wb_t		wb,							// From exec unit
	output	opnd_t		opnd						// To operand network
);

	data_t				regs [NUM_REGS];			// Architectural registers

	////////////////////
	// Write port
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;						// All registers read zero
		end
		else if (wb.valid) begin
			regs[wb.dst] <= wb.data;
		end
	end

	////////////////////
	// Read ports
	// Same-cycle write not visible here, the bypass window covers it
	always_ff @(posedge clock) begin
		if (reset) begin
			opnd <= '0;
		end
		else begin
			opnd.dec	<= dec;						// Control rides along
			opnd.data1	<= regs[dec.src1_idx];
			opnd.data2	<= regs[dec.src2_idx];
			opnd.data3	<= regs[dec.src3_idx];
		end
	end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build the lane testbench with Verilator and run it; exit status follows the run
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module tb_lane -f all.f -o sim_lane &&
./obj_dir/sim_lane || exit 1

//--- tb_lane.sv
// Lane testbench driving random and directed instructions against a sequential model
`timescale 1ns/1ps
`default_nettype none

module tb_lane
	import pkg_tpu::*;
	import pkg_isa::*;
();

	typedef struct packed {
		logic		is_pac;							// PAC port item
		wb_t		wb;
		data_t		pac;
		int			due;							// Cycle the result must show
	} exp_t;

	logic		clock;
	logic		reset;
	logic		instr_valid;
	instr_t		instr;
	logic		result_valid;
	index_t		result_dst;
	data_t		result_data;
	logic		pac_valid;
	data_t		pac_data;
	wb_t		act_wb;								// Result port as one word

	integer		seed = 35;
	int			cyc = 0;
	int			drain_cnt;
	data_t		model_regs [NUM_REGS];				// Sequential model state
	exp_t		exp_q [$];
	string		name_q [$];
	exp_t		head;
	string		head_name;
	opcode_t	alu_ops [6] = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_MAD};

	lane_top #(
		.NUM_REGS			(NUM_REGS),
		.BYPASS_BUFF_SIZE	(BYPASS_BUFF_SIZE)
	) dut0 (
		.clock			(clock),
		.reset			(reset),
		.instr_valid	(instr_valid),
		.instr			(instr),
		.result_valid	(result_valid),
		.result_dst		(result_dst),
		.result_data	(result_data),
		.pac_valid		(pac_valid),
		.pac_data		(pac_data)
	);

	assign act_wb = {result_valid, result_dst, result_data};

	always #2 clock = ~clock;						// 4 ns period

	always @(posedge clock)
		cyc <= cyc + 1;

	////////////////////
	// Checks
	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("test failed");
		$fatal(1, "stopping at first error");
	endtask

	task automatic compare_wb(input string name, input wb_t exp, input wb_t act);
		string		exp_str;
		string		act_str;
		exp_str = $sformatf("valid=%b dst=%0d data=%h", exp.valid, exp.dst, exp.data);
		act_str = $sformatf("valid=%b dst=%0d data=%h", act.valid, act.dst, act.data);
		if (act !== exp)
			abort_run($sformatf("ERROR %s: expected %s, actual %s", name, exp_str, act_str));
	endtask

	task automatic compare_pac(input string name, input data_t exp, input data_t act);
		if (act !== exp)
			abort_run($sformatf("ERROR %s: expected pac_data=%h, actual pac_data=%h",
				name, exp, act));
	endtask

	////////////////////
	// Stimulus helpers
	function automatic instr_t make_r(input opcode_t op, input index_t d, input index_t a,
		input index_t b, input index_t c, input logic [1:0] sel);
		instr_t		w;
		w			= '0;
		w.r.opcode	= op;
		w.r.dst		= d;
		w.r.src1	= a;
		w.r.src2	= b;
		w.r.src3	= c;
		w.r.pac_sel	= sel;
		return w;
	endfunction

	function automatic instr_t make_i(input opcode_t op, input index_t d, input index_t a,
		input logic [15:0] imm);
		instr_t		w;
		w			= '0;
		w.i.opcode	= op;
		w.i.dst		= d;
		w.i.src1	= a;
		w.i.imm		= imm;
		return w;
	endfunction

	// Mostly r0..r7 so dependencies stay dense
	function automatic index_t pick_idx();
		if (($random(seed) & 3) != 0)
			return index_t'($unsigned($random(seed)) % 8);
		else
			return index_t'($unsigned($random(seed)) % 32);
	endfunction

	function automatic logic [5:0] pick_code();
		int		r;
		r = $unsigned($random(seed)) % 12;
		if (r < 10)
			return 6'(r);							// Defined opcodes
		else
			return 6'(10 + $unsigned($random(seed)) % 54);	// Unknown 0x0A..0x3F
	endfunction

	function automatic instr_t rand_instr(input logic [5:0] code);
		logic [31:0]	raw;
		instr_t			w;
		raw			= $random(seed);
		raw[31:26]	= code;							// Opcode on top in both forms
		w			= raw;
		w.r.dst		= pick_idx();
		w.r.src1	= pick_idx();
		if (code != OP_ADDI) begin					// Keep the immediate random
			w.r.src2	= pick_idx();
			w.r.src3	= pick_idx();
		end
		return w;
	endfunction

	// Executes one instruction in order and queues what the lane must emit
	task automatic run_model(input instr_t w, input string name);
		data_t		s1;
		data_t		s2;
		data_t		s3;
		data_t		res;
		logic		wr;
		exp_t		e;
		s1	= model_regs[w.r.src1];
		s2	= model_regs[w.r.src2];
		s3	= model_regs[w.r.src3];
		wr	= 1'b1;
		res	= '0;
		e	= '0;
		e.due = cyc + 4;
		case (w.r.opcode)
			OP_ADD:		res = s1 + s2;
			OP_SUB:		res = s1 - s2;
			OP_AND:		res = s1 & s2;
			OP_OR:		res = s1 | s2;
			OP_XOR:		res = s1 ^ s2;
			OP_MAD:		res = s1 * s2 + s3;			// Wraps at 32 bits
			OP_ADDI:	res = model_regs[w.i.src1] + {{16{w.i.imm[15]}}, w.i.imm};
			OP_MOV:		res = s1;
			default:	wr = 1'b0;					// PAC, NOP, unknown
		endcase
		if (wr) begin
			model_regs[w.r.dst]	= res;
			e.wb				= {1'b1, w.r.dst, res};
			exp_q.push_back(e);
			name_q.push_back(name);
		end
		else if (w.r.opcode == OP_PAC && w.r.pac_sel != 2'd0) begin
			e.is_pac	= 1'b1;
			e.pac		= (w.r.pac_sel == 2'd1) ? s1 : (w.r.pac_sel == 2'd2) ? s2 : s3;
			exp_q.push_back(e);
			name_q.push_back(name);
		end
	endtask

	task automatic issue(input instr_t w, input string name);
		instr_valid	= 1'b1;
		instr		= w;
		run_model(w, name);
		@(negedge clock);
		instr_valid	= 1'b0;
		instr		= '0;
	endtask

	task automatic idle(input int n);
		repeat (n) @(negedge clock);
	endtask

	////////////////////
	// Output monitor
	always @(negedge clock) begin
		if (!reset) begin
			if (exp_q.size() != 0 && exp_q[0].due < cyc)
				abort_run($sformatf("result for %s did not arrive on its cycle", name_q[0]));
			else if (result_valid || pac_valid) begin
				if (exp_q.size() == 0)
					abort_run("lane produced an output that no instruction asked for");
				else begin
					head		= exp_q.pop_front();
					head_name	= name_q.pop_front();
					if (head.due != cyc)
						abort_run($sformatf("result for %s arrived early", head_name));
					else if (head.is_pac != pac_valid || head.is_pac == result_valid)
						abort_run($sformatf("result for %s came on the wrong port", head_name));
					else if (head.is_pac)
						compare_pac(head_name, head.pac, pac_data);
					else
						compare_wb(head_name, head.wb, act_wb);
				end
			end
		end
	end

	////////////////////
	// Test sequence
	initial begin
		clock		= 1'b0;
		reset		= 1'b1;
		instr_valid	= 1'b0;
		instr		= '0;
		for (int i = 0; i < NUM_REGS; i++)
			model_regs[i] = '0;
		repeat (4) @(negedge clock);				// 4 reset cycles
		reset = 1'b0;
		@(negedge clock);
		compare_wb("reset_state", '0, act_wb);
		compare_pac("reset_state", '0, pac_data);
		idle(4);									// Monitor flags any valid here

		for (int i = 0; i < NUM_REGS; i++)			// Every register reads zero
			issue(make_r(OP_PAC, 5'd0, index_t'(i), index_t'(i), index_t'(i),
				2'(1 + i % 3)), "reset_pac_read");

		for (int i = 1; i < 8; i++)
			issue(make_i(OP_ADDI, index_t'(i), 5'd0, 16'($random(seed))), "seed_regs");
		idle(5);
		for (int k = 0; k < 6; k++) begin			// One ALU op at a time
			issue(make_r(alu_ops[k], index_t'(8 + k), index_t'(1 + k), index_t'(2 + k),
				index_t'(3 + k), 2'd0), "alu_ops");
			idle(5);
		end
		issue(make_i(OP_ADDI, 5'd15, 5'd3, 16'hfb2e), "addi_negative");
		idle(5);

		for (int d = 1; d <= 5; d++) begin			// Consumer at distance d
			issue(make_i(OP_ADDI, 5'd10, 5'd10, 16'(d * 7)), "dependency");
			for (int f = 1; f < d; f++)
				issue(make_r(OP_XOR, index_t'(20 + f), 5'd3, 5'd4, 5'd0, 2'd0), "dependency");
			issue(make_r(OP_SUB, 5'd11, 5'd10, 5'd3, 5'd0, 2'd0), "dependency");
			issue(make_r(OP_MAD, 5'd10, 5'd11, 5'd10, 5'd10, 2'd0), "dependency");
			idle(6);
		end

		issue(make_r(OP_MOV, 5'd12, 5'd5, 5'd0, 5'd0, 2'd0), "mov");
		for (int k = 1; k <= 3; k++)				// dst field must be ignored
			issue(make_r(OP_PAC, 5'd5, 5'd12, 5'd1, 5'd2, 2'(k)), "pac_select");
		issue(make_r(OP_PAC, 5'd0, 5'd5, 5'd0, 5'd0, 2'd1), "pac_no_write");
		idle(6);

		issue(rand_instr(6'h00), "nop");
		issue(rand_instr(6'h2a), "unknown_op");
		issue(rand_instr(6'h3f), "unknown_op");
		issue(make_r(OP_PAC, 5'd0, 5'd1, 5'd2, 5'd3, 2'd0), "pac_sel_zero");
		idle(6);

		for (int n = 0; n < 2000; n++) begin
			issue(rand_instr(pick_code()), "random_mix");
			if (($random(seed) & 3) == 0)
				idle(1 + $unsigned($random(seed)) % 3);	// Random gap
		end

		drain_cnt = 0;
		while (exp_q.size() != 0 && drain_cnt < 50) begin
			@(negedge clock);
			drain_cnt++;
		end
		idle(4);
		if (exp_q.size() != 0)
			abort_run("results still outstanding after the drain timeout");
		else begin
			$display("test passed");
			$finish;
		end
	end

endmodule

`default_nettype wire
